/* csr_arch_pkg.sv */
`default_nettype none

package csr_arch_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Unprivileged counter views
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE    = 12'hc00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIME     = 12'hc01;
    localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH   = 12'hc80;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TIMEH    = 12'hc81;

    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE   = 12'hb00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH  = 12'hb80;

    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;

    // MXL=1 with the I and M extension bits
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100;

    // Exception codes
    localparam logic [XLEN-1:0] CAUSE_INST_MISALIGNED   = 32'd0;
    localparam logic [XLEN-1:0] CAUSE_INST_ACCESS_FAULT = 32'd1;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INST      = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT        = 32'd3;
    localparam logic [XLEN-1:0] CAUSE_ECALL_U           = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M           = 32'd11;

    // Interrupt codes carry the top bit
    localparam logic [XLEN-1:0] CAUSE_M_TIMER_INTR = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INTR   = 32'h8000_000b;

    // Field positions, shared by mip and mie
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIE_MEIE_BIT     = 11;

    localparam logic [1:0] XTVEC_VECTORED = 2'b01;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_mode_t;

endpackage

`default_nettype wire

/* csr_stage_pkg.sv */
`default_nettype none

package csr_stage_pkg;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

    // One instruction, held steady over its A and B cycles
    typedef struct packed {
        logic                                  valid;
        logic                                  is_new;
        logic [csr_arch_pkg::XLEN-1:0]         pc;
        logic [csr_arch_pkg::XLEN-1:0]         inst;
        csr_cmd_t                              cmd;
        logic [csr_arch_pkg::CSR_ADDR_W-1:0]   addr;
        logic [csr_arch_pkg::XLEN-1:0]         op1;
        logic                                  exc_valid;
        logic [csr_arch_pkg::XLEN-1:0]         exc_cause;
    } csr_req_t;

    // Free-running counters from outside the stage
    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] time_cnt;
        logic [63:0] mtime;
        logic [63:0] mtimecmp;
    } csr_timer_t;

    typedef struct packed {
        logic                          stall;
        logic                          is_trap;
        logic                          no_wb;
        logic [csr_arch_pkg::XLEN-1:0] trap_vector;
        logic [csr_arch_pkg::XLEN-1:0] rdata;
    } csr_resp_t;

    // Decoded view of a request
    typedef struct packed {
        logic                          is_write;
        logic                          is_mret;
        logic                          illegal;
        logic [csr_arch_pkg::XLEN-1:0] wdata_op;
        logic                          mret_ok;
    } csr_dec_t;

endpackage

`default_nettype wire

/* csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  csr_stage_pkg::csr_req_t   req,
    input  csr_arch_pkg::priv_mode_t  mode,
    output csr_stage_pkg::csr_dec_t   dec
);

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    logic wr_cmd;
    logic can_access;
    logic read_only;
    logic mret_cmd;

    // Address bits [9:8] give the lowest privilege allowed to write
    assign can_access = req.addr[9:8] <= mode;
    assign read_only  = req.addr[11:10] == 2'b11;

    always_comb begin
        wr_cmd   = 1'b0;
        mret_cmd = 1'b0;
        case (req.cmd)
            CMD_W, CMD_S, CMD_C: begin
                wr_cmd = 1'b1;
            end
            CMD_MRET: begin
                mret_cmd = 1'b1;
            end
            default: begin
                wr_cmd   = 1'b0;
                mret_cmd = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec.is_mret = mret_cmd;
        dec.mret_ok = mret_cmd && (mode == M_MODE);

        // Writes to read-only space are dropped, not trapped
        dec.is_write = wr_cmd && can_access && !read_only;

        dec.illegal = (wr_cmd && !can_access) || (mret_cmd && mode != M_MODE);

        // Operand only matters for write commands
        dec.wdata_op = wr_cmd ? req.op1 : '0;
    end

endmodule

`default_nettype wire

/* csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  csr_stage_pkg::csr_req_t     req,
    input  csr_stage_pkg::csr_dec_t     dec,
    input  csr_stage_pkg::csr_timer_t   timer,
    input  wire                         ext_irq,
    input  wire                         take_trap,
    input  wire                         trap_is_intr,
    input  wire [31:0]                  trap_cause,
    input  wire [31:0]                  trap_tval,
    input  wire                         skip_write,
    output logic [31:0]                 rdata,
    output logic [31:0]                 mtvec,
    output logic [31:0]                 mepc,
    output logic                        mstatus_mie,
    output logic [1:0]                  irq_pend,
    output csr_arch_pkg::priv_mode_t    mode
);

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    logic        mstatus_mpie;
    priv_mode_t  mstatus_mpp;
    logic        mie_meie;
    logic        mie_mtie;
    logic        mip_meip;
    logic        mip_mtip;
    logic [31:0] mscratch;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mstatus_rd;
    logic [31:0] mie_rd;
    logic [31:0] mip_rd;
    logic [31:0] wdata;
    logic        a_cycle;
    logic        b_write;

    assign a_cycle = req.valid && req.is_new;
    assign b_write = req.valid && !req.is_new && dec.is_write && !skip_write;

    // Bit 1 external, bit 0 timer
    assign irq_pend = {mip_meip & mie_meie, mip_mtip & mie_mtie};

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT]       = mstatus_mie;
        mstatus_rd[MSTATUS_MPIE_BIT]      = mstatus_mpie;
        mstatus_rd[MSTATUS_MPP_LSB +: 2]  = mstatus_mpp;
        mie_rd = '0;
        mie_rd[MIE_MTIE_BIT] = mie_mtie;
        mie_rd[MIE_MEIE_BIT] = mie_meie;
        mip_rd = '0;
        mip_rd[MIE_MTIE_BIT] = mip_mtip;
        mip_rd[MIE_MEIE_BIT] = mip_meip;
    end

    always_comb begin
        case (req.addr)
            ADDR_CYCLE, ADDR_MCYCLE:   rdata = timer.cycle[31:0];
            ADDR_CYCLEH, ADDR_MCYCLEH: rdata = timer.cycle[63:32];
            ADDR_TIME:                 rdata = timer.time_cnt[31:0];
            ADDR_TIMEH:                rdata = timer.time_cnt[63:32];
            ADDR_MSTATUS:              rdata = mstatus_rd;
            ADDR_MISA:                 rdata = MISA_VALUE;
            ADDR_MIE:                  rdata = mie_rd;
            ADDR_MTVEC:                rdata = mtvec;
            ADDR_MSCRATCH:             rdata = mscratch;
            ADDR_MEPC:                 rdata = mepc;
            ADDR_MCAUSE:               rdata = mcause;
            ADDR_MTVAL:                rdata = mtval;
            ADDR_MIP:                  rdata = mip_rd;
            default:                   rdata = '0;
        endcase
    end

    always_comb begin
        case (req.cmd)
            CMD_W:   wdata = dec.wdata_op;
            CMD_S:   wdata = rdata | dec.wdata_op;
            CMD_C:   wdata = rdata & ~dec.wdata_op;
            default: wdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode         <= M_MODE;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= U_MODE;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mip_meip     <= 1'b0;
            mip_mtip     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (a_cycle && take_trap) begin
            // Trap entry, always to M-mode
            mode         <= M_MODE;
            mcause       <= trap_cause;
            mepc         <= req.pc;
            mtval        <= trap_tval;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= mode;
            if (trap_is_intr) begin
                if (trap_cause == CAUSE_M_EXT_INTR) begin
                    mip_meip <= 1'b0;
                end else begin
                    mip_mtip <= 1'b0;
                end
            end
        end else if (a_cycle) begin
            // Sample pending sources only on a quiet A cycle
            mip_mtip <= timer.mtime >= timer.mtimecmp;
            mip_meip <= ext_irq;
            if (dec.mret_ok) begin
                mode         <= mstatus_mpp;
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= U_MODE;
            end
        end else if (b_write) begin
            case (req.addr)
                ADDR_MSTATUS: begin
                    mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                    // Only U and M exist, anything else reads back as U
                    mstatus_mpp  <= (wdata[MSTATUS_MPP_LSB +: 2] == M_MODE) ? M_MODE : U_MODE;
                end
                ADDR_MIE: begin
                    mie_mtie <= wdata[MIE_MTIE_BIT];
                    mie_meie <= wdata[MIE_MEIE_BIT];
                end
                ADDR_MTVEC:    mtvec    <= wdata;
                ADDR_MSCRATCH: mscratch <= wdata;
                ADDR_MEPC:     mepc     <= {wdata[31:2], 2'b00};
                ADDR_MCAUSE:   mcause   <= wdata;
                ADDR_MTVAL:    mtval    <= wdata;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  csr_stage_pkg::csr_req_t   req,
    input  csr_stage_pkg::csr_dec_t   dec,
    input  csr_arch_pkg::priv_mode_t  mode,
    input  wire                       mstatus_mie,
    input  wire [1:0]                 irq_pend,
    input  wire [31:0]                mtvec,
    output logic                      take_trap,
    output logic                      trap_is_intr,
    output logic [31:0]               trap_cause,
    output logic [31:0]               trap_tval,
    output logic [31:0]               trap_target
);

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    logic        is_ecall;
    logic        raise_exc;
    logic        intr_en;
    logic        raise_intr;
    logic [31:0] exc_cause;
    logic [31:0] intr_cause;
    logic [31:0] exc_tval;
    logic [31:0] tvec_base;

    assign is_ecall  = req.cmd == CMD_ECALL;
    assign raise_exc = req.exc_valid || is_ecall || dec.illegal;

    // U-mode interrupts are never masked by mstatus.MIE
    assign intr_en    = (mode == U_MODE) || mstatus_mie;
    assign raise_intr = intr_en && (irq_pend != 2'b00);

    always_comb begin
        if (req.exc_valid) begin
            exc_cause = req.exc_cause;
        end else if (is_ecall) begin
            exc_cause = (mode == U_MODE) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        end else begin
            exc_cause = CAUSE_ILLEGAL_INST;
        end
    end

    // External before timer
    assign intr_cause = irq_pend[1] ? CAUSE_M_EXT_INTR : CAUSE_M_TIMER_INTR;

    always_comb begin
        case (exc_cause)
            CAUSE_INST_MISALIGNED, CAUSE_INST_ACCESS_FAULT, CAUSE_BREAKPOINT: begin
                exc_tval = req.pc;
            end
            CAUSE_ILLEGAL_INST: begin
                exc_tval = req.inst;
            end
            default: begin
                exc_tval = '0;
            end
        endcase
    end

    // Exceptions win over a pending interrupt
    assign take_trap    = req.valid && req.is_new && (raise_exc || raise_intr);
    assign trap_is_intr = !raise_exc && raise_intr;
    assign trap_cause   = raise_exc ? exc_cause : intr_cause;
    assign trap_tval    = raise_exc ? exc_tval : '0;

    assign tvec_base = {mtvec[31:2], 2'b00};

    always_comb begin
        if (mtvec[1:0] == XTVEC_VECTORED) begin
            // Only interrupts are spread over the table
            trap_target = trap_is_intr ? tvec_base + {trap_cause[29:0], 2'b00} : tvec_base;
        end else begin
            trap_target = mtvec;
        end
    end

endmodule

`default_nettype wire

/* csr_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_commit (
    input  wire                       clk,
    input  wire                       rst_n,
    input  csr_stage_pkg::csr_req_t   req,
    input  csr_stage_pkg::csr_dec_t   dec,
    input  wire                       take_trap,
    input  wire [31:0]                trap_target,
    input  wire [31:0]                rdata,
    input  wire [31:0]                mepc,
    output csr_stage_pkg::csr_resp_t  resp,
    output logic                      skip_write
);

    import csr_stage_pkg::*;

    logic        a_cycle;
    logic        wr_cmd;
    logic        trap_q;
    logic        ret_q;
    logic [31:0] vector_q;
    logic [31:0] rdata_q;

    assign a_cycle = req.valid && req.is_new;
    assign wr_cmd  = req.cmd inside {CMD_W, CMD_S, CMD_C};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trap_q   <= 1'b0;
            ret_q    <= 1'b0;
            vector_q <= '0;
            rdata_q  <= '0;
        end else begin
            // Flags live for the B cycle only
            trap_q <= a_cycle && take_trap;
            ret_q  <= a_cycle && !take_trap && dec.mret_ok;
            if (a_cycle) begin
                if (take_trap) begin
                    vector_q <= trap_target;
                end else if (dec.mret_ok) begin
                    vector_q <= mepc;
                end else begin
                    vector_q <= '0;
                end
                if (!take_trap) begin
                    rdata_q <= rdata;
                end
            end
        end
    end

    assign skip_write = trap_q || ret_q;

    always_comb begin
        resp.stall       = a_cycle && (take_trap || dec.is_mret || wr_cmd);
        resp.is_trap     = req.valid && !req.is_new && (trap_q || ret_q);
        resp.no_wb       = req.valid && (take_trap || trap_q);
        resp.trap_vector = vector_q;
        resp.rdata       = rdata_q;
    end

endmodule

`default_nettype wire

/* csr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  csr_stage_pkg::csr_req_t   req,
    input  csr_stage_pkg::csr_timer_t timer,
    input  wire                       ext_irq,
    output csr_stage_pkg::csr_resp_t  resp,
    output csr_arch_pkg::priv_mode_t  mode
);

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    csr_dec_t    dec;
    logic [31:0] rdata;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic        mstatus_mie;
    logic [1:0]  irq_pend;
    logic        take_trap;
    logic        trap_is_intr;
    logic [31:0] trap_cause;
    logic [31:0] trap_tval;
    logic [31:0] trap_target;
    logic        skip_write;

    csr_decode u_decode (
        .req  (req),
        .mode (mode),
        .dec  (dec)
    );

    csr_file u_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .dec          (dec),
        .timer        (timer),
        .ext_irq      (ext_irq),
        .take_trap    (take_trap),
        .trap_is_intr (trap_is_intr),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .skip_write   (skip_write),
        .rdata        (rdata),
        .mtvec        (mtvec),
        .mepc         (mepc),
        .mstatus_mie  (mstatus_mie),
        .irq_pend     (irq_pend),
        .mode         (mode)
    );

    trap_ctrl u_trap (
        .req          (req),
        .dec          (dec),
        .mode         (mode),
        .mstatus_mie  (mstatus_mie),
        .irq_pend     (irq_pend),
        .mtvec        (mtvec),
        .take_trap    (take_trap),
        .trap_is_intr (trap_is_intr),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .trap_target  (trap_target)
    );

    csr_commit u_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .dec         (dec),
        .take_trap   (take_trap),
        .trap_target (trap_target),
        .rdata       (rdata),
        .mepc        (mepc),
        .resp        (resp),
        .skip_write  (skip_write)
    );

endmodule

`default_nettype wire

/* csr_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_stage_asserts (
    input  wire                        clk,
    input  wire                        rst_n,
    input  csr_stage_pkg::csr_req_t    req,
    input  csr_stage_pkg::csr_resp_t   resp,
    input  csr_arch_pkg::priv_mode_t   mode
);

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    int fail_count;

    initial fail_count = 0;

    // Stall only holds an A cycle, and without a write or MRET it comes from a trap
    stall_in_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp.stall |-> req.valid && req.is_new &&
            (resp.no_wb || (req.cmd inside {CMD_W, CMD_S, CMD_C, CMD_MRET})))
    else begin
        $error("stall raised outside the first cycle or without a trap, write or MRET");
        fail_count++;
    end

    // Redirect only in a B cycle that follows a stalled A cycle
    trap_in_b: assert property (@(posedge clk) disable iff (!rst_n)
        resp.is_trap |-> req.valid && !req.is_new && $past(resp.stall))
    else begin
        $error("is_trap raised outside the second cycle of a stalled instruction");
        fail_count++;
    end

    // First cycle out of reset is quiet, in M-mode
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (resp == '0) && (mode == M_MODE))
    else begin
        $error("outputs not idle in the first cycle after reset");
        fail_count++;
    end

endmodule

bind csr_stage csr_stage_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .resp  (resp),
    .mode  (mode)
);

`default_nettype wire

/* tb_csr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_stage;

    import csr_arch_pkg::*;
    import csr_stage_pkg::*;

    typedef enum logic [1:0] {PH_IDLE, PH_A, PH_B} phase_t;

    // Instructions issued by all five tests, three cycles each
    localparam int NUM_INSTR  = 45;
    localparam int TIMEOUT_NS = (NUM_INSTR * 3 + 4 + 50) * 100;

    logic       clk;
    logic       rst_n;
    csr_req_t   req;
    csr_timer_t timer;
    logic       ext_irq;
    csr_resp_t  resp;
    priv_mode_t mode;

    phase_t      phase;
    csr_resp_t   exp_resp;
    priv_mode_t  exp_mode;
    logic        exp_stall;
    int          error_count;
    int          check_count;
    int          tests_failed;
    int          issued;
    logic [31:0] lcg_state;
    logic [31:0] next_pc;

    // Reference copy of the architectural state
    priv_mode_t  ref_mode;
    priv_mode_t  ref_mpp;
    logic        ref_mie_bit;
    logic        ref_mpie;
    logic        ref_meie;
    logic        ref_mtie;
    logic        ref_meip;
    logic        ref_mtip;
    logic [31:0] ref_mtvec;
    logic [31:0] ref_mscratch;
    logic [31:0] ref_mepc;
    logic [31:0] ref_mcause;
    logic [31:0] ref_mtval;
    logic [31:0] ref_rdata_saved;

    csr_stage u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .timer   (timer),
        .ext_irq (ext_irq),
        .resp    (resp),
        .mode    (mode)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic reset_model();
        ref_mode        = M_MODE;
        ref_mpp         = U_MODE;
        ref_mie_bit     = 1'b0;
        ref_mpie        = 1'b0;
        ref_meie        = 1'b0;
        ref_mtie        = 1'b0;
        ref_meip        = 1'b0;
        ref_mtip        = 1'b0;
        ref_mtvec       = '0;
        ref_mscratch    = '0;
        ref_mepc        = '0;
        ref_mcause      = '0;
        ref_mtval       = '0;
        ref_rdata_saved = '0;
    endtask

    function automatic logic [31:0] model_csr_value(input logic [11:0] addr,
                                                    input csr_timer_t t);
        logic [31:0] v;
        v = '0;
        case (addr)
            ADDR_CYCLE, ADDR_MCYCLE:   v = t.cycle[31:0];
            ADDR_CYCLEH, ADDR_MCYCLEH: v = t.cycle[63:32];
            ADDR_TIME:                 v = t.time_cnt[31:0];
            ADDR_TIMEH:                v = t.time_cnt[63:32];
            ADDR_MISA:                 v = MISA_VALUE;
            ADDR_MSTATUS: begin
                v[MSTATUS_MIE_BIT]      = ref_mie_bit;
                v[MSTATUS_MPIE_BIT]     = ref_mpie;
                v[MSTATUS_MPP_LSB +: 2] = ref_mpp;
            end
            ADDR_MIE: begin
                v[MIE_MTIE_BIT] = ref_mtie;
                v[MIE_MEIE_BIT] = ref_meie;
            end
            ADDR_MIP: begin
                v[MIE_MTIE_BIT] = ref_mtip;
                v[MIE_MEIE_BIT] = ref_meip;
            end
            ADDR_MTVEC:    v = ref_mtvec;
            ADDR_MSCRATCH: v = ref_mscratch;
            ADDR_MEPC:     v = ref_mepc;
            ADDR_MCAUSE:   v = ref_mcause;
            ADDR_MTVAL:    v = ref_mtval;
            default:       v = '0;
        endcase
        return v;
    endfunction

    // Whole instruction, A cycle then B cycle, on the reference state
    function automatic csr_resp_t expect_step(input csr_req_t r, input csr_timer_t t,
                                              input logic irq, output priv_mode_t m_out,
                                              output logic stall_out);
        csr_resp_t   rsp;
        logic        wr;
        logic        mret;
        logic        illegal;
        logic        exc;
        logic        ext_p;
        logic        tim_p;
        logic        intr;
        logic        trap;
        logic [31:0] cause;
        logic [31:0] tval;
        logic [31:0] base;
        logic [31:0] target;
        logic [31:0] cur;
        logic [31:0] wdata;
        wr      = (r.cmd == CMD_W) || (r.cmd == CMD_S) || (r.cmd == CMD_C);
        mret    = r.cmd == CMD_MRET;
        illegal = (wr && (r.addr[9:8] > ref_mode)) || (mret && ref_mode != M_MODE);
        exc     = r.exc_valid || (r.cmd == CMD_ECALL) || illegal;
        ext_p   = ref_meip && ref_meie;
        tim_p   = ref_mtip && ref_mtie;
        intr    = ((ref_mode == U_MODE) || ref_mie_bit) && (ext_p || tim_p);
        trap    = exc || intr;
        if (r.exc_valid) cause = r.exc_cause;
        else if (r.cmd == CMD_ECALL) cause = (ref_mode == U_MODE) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        else if (illegal) cause = CAUSE_ILLEGAL_INST;
        else if (ext_p) cause = CAUSE_M_EXT_INTR;
        else cause = CAUSE_M_TIMER_INTR;
        tval = '0;
        if (exc && (cause == CAUSE_INST_MISALIGNED || cause == CAUSE_INST_ACCESS_FAULT ||
                    cause == CAUSE_BREAKPOINT)) tval = r.pc;
        else if (exc && cause == CAUSE_ILLEGAL_INST) tval = r.inst;
        base = {ref_mtvec[31:2], 2'b00};
        if (ref_mtvec[1:0] != XTVEC_VECTORED) target = ref_mtvec;
        else if (exc) target = base;
        else target = base + 32'd4 * cause;
        rsp       = '0;
        stall_out = trap || mret || wr;
        cur       = model_csr_value(r.addr, t);
        if (trap) begin
            ref_mcause  = cause;
            ref_mepc    = r.pc;
            ref_mtval   = tval;
            ref_mpie    = ref_mie_bit;
            ref_mie_bit = 1'b0;
            ref_mpp     = ref_mode;
            ref_mode    = M_MODE;
            if (!exc && ext_p) ref_meip = 1'b0;
            else if (!exc) ref_mtip = 1'b0;
            rsp.is_trap     = 1'b1;
            rsp.no_wb       = 1'b1;
            rsp.trap_vector = target;
        end else begin
            ref_rdata_saved = cur;
            ref_mtip = t.mtime >= t.mtimecmp;
            ref_meip = irq;
            if (mret) begin
                rsp.is_trap     = 1'b1;
                rsp.trap_vector = ref_mepc;
                ref_mode        = ref_mpp;
                ref_mie_bit     = ref_mpie;
                ref_mpie        = 1'b1;
                ref_mpp         = U_MODE;
            end
        end
        rsp.rdata = ref_rdata_saved;
        // Cycle B write, read value taken after the A update
        if (!trap && wr && r.addr[11:10] != 2'b11) begin
            cur = model_csr_value(r.addr, t);
            if (r.cmd == CMD_W) wdata = r.op1;
            else if (r.cmd == CMD_S) wdata = cur | r.op1;
            else wdata = cur & ~r.op1;
            case (r.addr)
                ADDR_MSTATUS: begin
                    ref_mie_bit = wdata[MSTATUS_MIE_BIT];
                    ref_mpie    = wdata[MSTATUS_MPIE_BIT];
                    ref_mpp = (wdata[MSTATUS_MPP_LSB +: 2] == 2'b11) ? M_MODE : U_MODE;
                end
                ADDR_MIE: begin
                    ref_mtie = wdata[MIE_MTIE_BIT];
                    ref_meie = wdata[MIE_MEIE_BIT];
                end
                ADDR_MTVEC:    ref_mtvec    = wdata;
                ADDR_MSCRATCH: ref_mscratch = wdata;
                ADDR_MEPC:     ref_mepc     = {wdata[31:2], 2'b00};
                ADDR_MCAUSE:   ref_mcause   = wdata;
                ADDR_MTVAL:    ref_mtval    = wdata;
                default: begin
                end
            endcase
        end
        m_out = ref_mode;
        return rsp;
    endfunction

    task automatic issue(input csr_cmd_t cmd, input logic [11:0] addr, input logic [31:0] op1,
                         input logic exc_v, input logic [31:0] exc_c);
        csr_req_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.is_new    = 1'b1;
        r.pc        = next_pc;
        r.inst      = lcg_next();
        r.cmd       = cmd;
        r.addr      = addr;
        r.op1       = op1;
        r.exc_valid = exc_v;
        r.exc_cause = exc_c;
        next_pc     = next_pc + 32'd4;
        @(posedge clk);
        #1;
        req      = r;
        exp_resp = expect_step(r, timer, ext_irq, exp_mode, exp_stall);
        phase    = PH_A;
        @(posedge clk);
        #1;
        req.is_new = 1'b0;
        phase      = PH_B;
        @(posedge clk);
        #1;
        req    = '0;
        phase  = PH_IDLE;
        issued = issued + 1;
    endtask

    task automatic read_csr(input logic [11:0] addr);
        issue(CMD_NONE, addr, '0, 1'b0, '0);
    endtask

    task automatic csr_op(input csr_cmd_t cmd, input logic [11:0] addr, input logic [31:0] op1);
        issue(cmd, addr, op1, 1'b0, '0);
    endtask

    task automatic report_test(input string name, input int err_before);
        int n;
        n = error_count - err_before;
        if (n == 0) begin
            $display("[%0t] %s: pass", $time, name);
        end else begin
            $display("[%0t] %s: fail with %0d errors", $time, name, n);
            tests_failed = tests_failed + 1;
        end
    endtask

    // Stall and no_wb in A, the full response and the mode in B
    always @(negedge clk) begin
        if (phase == PH_A) begin
            check_count = check_count + 1;
            assert (resp.stall === exp_stall && resp.no_wb === exp_resp.no_wb) else begin
                $display("ERROR %0t: stall=%0b no_wb=%0b, expected stall=%0b no_wb=%0b", $time,
                         resp.stall, resp.no_wb, exp_stall, exp_resp.no_wb);
                error_count = error_count + 1;
            end
        end else if (phase == PH_B) begin
            check_count = check_count + 2;
            assert (resp === exp_resp) else begin
                $display("ERROR %0t: resp trap=%0b no_wb=%0b vec=%h rdata=%h", $time,
                         resp.is_trap, resp.no_wb, resp.trap_vector, resp.rdata);
                $display("ERROR %0t: expected trap=%0b no_wb=%0b vec=%h rdata=%h", $time,
                         exp_resp.is_trap, exp_resp.no_wb, exp_resp.trap_vector, exp_resp.rdata);
                error_count = error_count + 1;
            end
            assert (mode === exp_mode) else begin
                $display("ERROR %0t: mode is %0d, expected %0d", $time, mode, exp_mode);
                error_count = error_count + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int          err_before;
        logic [31:0] base;
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = '0;
        ext_irq        = 1'b0;
        timer          = '0;
        timer.mtimecmp = '1;
        phase          = PH_IDLE;
        error_count    = 0;
        check_count    = 0;
        tests_failed   = 0;
        issued         = 0;
        lcg_state      = 32'd93578;
        next_pc        = 32'h0000_1000;
        reset_model();
        timer.cycle    = {lcg_next(), lcg_next()};
        timer.time_cnt = {lcg_next(), lcg_next()};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        err_before = error_count;
        read_csr(ADDR_MISA);
        read_csr(ADDR_MSTATUS);
        read_csr(ADDR_CYCLE);
        read_csr(ADDR_CYCLEH);
        read_csr(ADDR_TIME);
        read_csr(ADDR_TIMEH);
        report_test("reset values", err_before);

        err_before = error_count;
        csr_op(CMD_W, ADDR_MSCRATCH, lcg_next());
        csr_op(CMD_S, ADDR_MSCRATCH, lcg_next());
        csr_op(CMD_C, ADDR_MSCRATCH, lcg_next());
        read_csr(ADDR_MSCRATCH);
        csr_op(CMD_W, ADDR_MEPC, lcg_next());
        csr_op(CMD_S, ADDR_MEPC, lcg_next());
        csr_op(CMD_C, ADDR_MEPC, lcg_next());
        read_csr(ADDR_MEPC);
        csr_op(CMD_W, ADDR_CYCLE, lcg_next());
        read_csr(ADDR_CYCLE);
        csr_op(CMD_W, ADDR_MISA, lcg_next());
        read_csr(ADDR_MISA);
        report_test("csr write set clear", err_before);

        err_before = error_count;
        csr_op(CMD_W, ADDR_MTVEC, lcg_next() & ~32'h3);
        csr_op(CMD_ECALL, '0, '0);
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MEPC);
        issue(CMD_W, ADDR_MSCRATCH, lcg_next(), 1'b1, CAUSE_INST_ACCESS_FAULT);
        read_csr(ADDR_MSCRATCH);
        report_test("ecall in m-mode", err_before);

        err_before = error_count;
        csr_op(CMD_W, ADDR_MEPC, lcg_next());
        csr_op(CMD_C, ADDR_MSTATUS, 32'h0000_1800);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_W, ADDR_MSCRATCH, lcg_next());
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MTVAL);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_ECALL, '0, '0);
        read_csr(ADDR_MCAUSE);
        report_test("u-mode and mret", err_before);

        err_before = error_count;
        issue(CMD_NONE, ADDR_MSCRATCH, '0, 1'b1, CAUSE_BREAKPOINT);
        read_csr(ADDR_MTVAL);
        base = lcg_next() & ~32'h3;
        csr_op(CMD_W, ADDR_MTVEC, base | 32'h1);
        csr_op(CMD_W, ADDR_MIE, 32'h0000_0880);
        csr_op(CMD_S, ADDR_MSTATUS, 32'h0000_0008);
        // Timer match and external line raised together
        timer.mtime    = 64'd500;
        timer.mtimecmp = 64'd400;
        ext_irq        = 1'b1;
        read_csr(ADDR_MSCRATCH);
        csr_op(CMD_W, ADDR_MSCRATCH, lcg_next());
        timer.mtimecmp = '1;
        ext_irq        = 1'b0;
        read_csr(ADDR_MIP);
        read_csr(ADDR_MCAUSE);
        read_csr(ADDR_MEPC);
        report_test("breakpoint and interrupts", err_before);

        $display("Done: %0d instr, %0d checks, %0d errors, %0d tests failed, %0d assert errors",
                 issued, check_count, error_count, tests_failed, u_dut.u_asserts.fail_count);
        if (error_count == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
csr_arch_pkg.sv
csr_stage_pkg.sv
csr_decode.sv
csr_file.sv
trap_ctrl.sv
csr_commit.sv
csr_stage.sv
csr_stage_asserts.sv
tb_csr_stage.sv
